// ==== compile.f ====
hdl/asa_tm_pkg.sv
hdl/asa_pkt_pkg.sv
hdl/asa_sync_fifo.sv
hdl/asa_copy_intake.sv
hdl/asa_read_count_tracker.sv
hdl/asa_enq_builder.sv
hdl/asa_release_merge.sv
hdl/asa_tm_interface.sv
test/tb_asa_tm_interface.sv

// ==== hdl/asa_copy_intake.sv ====
/* copy intake FIFO with back-pressure hysteresis, poll issue
   and the pending FIFO that waits for poll acks */
`timescale 1ns/1ns
`default_nettype none

module asa_copy_intake #(
	parameter int pending_depth = 32
) (
	input wire clk,
	input wire arst_n,
	input wire rep_enq_req,
	input wire rep_enq_ucast,
	input wire rep_enq_last,
	input wire rep_enq_drop,
	input wire [asa_pkt_pkg::PACKET_ID_NBITS-1:0] rep_enq_packet_id,
	input wire [asa_tm_pkg::QID_NBITS-1:0] rep_enq_qid,
	input wire asa_pkt_pkg::copy_desc_t rep_enq_desc,
	input wire tm_asa_poll_ack,
	output logic int_rep_bp,
	output logic asa_tm_poll_req,
	output logic [asa_tm_pkg::QID_NBITS-1:0] asa_tm_poll_qid,
	output logic [asa_pkt_pkg::PORT_ID_NBITS-1:0] asa_tm_poll_src_port,
	output logic ack_valid,
	output asa_pkt_pkg::pending_copy_t ack_copy
);

	localparam int intake_cnt_nbits = $clog2(asa_tm_pkg::INTAKE_DEPTH + 1);

	asa_pkt_pkg::pending_copy_t rep_copy;
	asa_pkt_pkg::pending_copy_t intake_head;
	logic intake_empty;
	logic [intake_cnt_nbits-1:0] intake_count;
	logic pend_full;
	logic intake_rd;

	assign rep_copy.ucast = rep_enq_ucast;
	assign rep_copy.last = rep_enq_last;
	assign rep_copy.drop = rep_enq_drop;
	assign rep_copy.packet_id = rep_enq_packet_id;
	assign rep_copy.qid = rep_enq_qid;
	assign rep_copy.desc = rep_enq_desc;

	// move one copy per cycle while the pending side has room
	assign intake_rd = !intake_empty && !pend_full;

	asa_sync_fifo #(
		.payload_t(asa_pkt_pkg::pending_copy_t),
		.depth(asa_tm_pkg::INTAKE_DEPTH)
	) u_intake_fifo (
		.clk(clk),
		.arst_n(arst_n),
		.wr(rep_enq_req),
		.din(rep_copy),
		.rd(intake_rd),
		.dout(intake_head),
		.empty(intake_empty),
		.full(),
		.count(intake_count)
	);

	// copies that were polled, popped in order by the acks
	asa_sync_fifo #(
		.payload_t(asa_pkt_pkg::pending_copy_t),
		.depth(pending_depth)
	) u_pending_fifo (
		.clk(clk),
		.arst_n(arst_n),
		.wr(intake_rd),
		.din(intake_head),
		.rd(tm_asa_poll_ack),
		.dout(ack_copy),
		.empty(),
		.full(pend_full),
		.count()
	);

	assign ack_valid = tm_asa_poll_ack;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			asa_tm_poll_req <= 1'b0;
			int_rep_bp <= 1'b0;
		end else begin
			asa_tm_poll_req <= intake_rd;
			if (intake_count >= intake_cnt_nbits'(asa_tm_pkg::BP_ON_LEVEL)) begin
				int_rep_bp <= 1'b1;
			end else if (intake_count <= intake_cnt_nbits'(asa_tm_pkg::BP_OFF_LEVEL)) begin
				int_rep_bp <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (intake_rd) begin
			asa_tm_poll_qid <= intake_head.qid;
			asa_tm_poll_src_port <= intake_head.desc.src_port;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/asa_enq_builder.sv ====
/* enqueue toward the traffic manager for each acknowledged copy */
`timescale 1ns/1ns
`default_nettype none

module asa_enq_builder (
	input wire clk,
	input wire arst_n,
	input wire ack_valid,
	input wire asa_pkt_pkg::pending_copy_t ack_copy,
	input wire tm_asa_poll_drop,
	input wire [asa_tm_pkg::CONN_ID_NBITS-1:0] tm_asa_poll_conn_id,
	input wire [asa_tm_pkg::CONN_GROUP_NBITS-1:0] tm_asa_poll_conn_group_id,
	input wire [asa_tm_pkg::PORT_QUEUE_NBITS-1:0] tm_asa_poll_port_queue_id,
	input wire [asa_pkt_pkg::PORT_ID_NBITS-1:0] tm_asa_poll_port_id,
	output logic asa_tm_enq_req,
	output logic [asa_tm_pkg::QID_NBITS-1:0] asa_tm_enq_qid,
	output logic [asa_tm_pkg::CONN_ID_NBITS-1:0] asa_tm_enq_conn_id,
	output logic [asa_tm_pkg::CONN_GROUP_NBITS-1:0] asa_tm_enq_conn_group_id,
	output logic [asa_tm_pkg::PORT_QUEUE_NBITS-1:0] asa_tm_enq_port_queue_id,
	output asa_pkt_pkg::copy_desc_t asa_tm_enq_desc
);

	asa_pkt_pkg::copy_desc_t acked_desc;
	asa_pkt_pkg::copy_desc_t desc_d1;
	logic keep_d1;
	logic [asa_tm_pkg::QID_NBITS-1:0] qid_d1;
	logic [asa_tm_pkg::CONN_ID_NBITS-1:0] conn_id_d1;
	logic [asa_tm_pkg::CONN_GROUP_NBITS-1:0] conn_group_id_d1;
	logic [asa_tm_pkg::PORT_QUEUE_NBITS-1:0] port_queue_id_d1;

	// egress port is decided by the traffic manager
	always_comb begin
		acked_desc = ack_copy.desc;
		acked_desc.dst_port = tm_asa_poll_port_id;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			keep_d1 <= 1'b0;
			asa_tm_enq_req <= 1'b0;
		end else begin
			keep_d1 <= ack_valid && !ack_copy.drop && !tm_asa_poll_drop;
			asa_tm_enq_req <= keep_d1;
		end
	end

	always_ff @(posedge clk) begin
		if (ack_valid) begin
			desc_d1 <= acked_desc;
			qid_d1 <= ack_copy.qid;
			conn_id_d1 <= tm_asa_poll_conn_id;
			conn_group_id_d1 <= tm_asa_poll_conn_group_id;
			port_queue_id_d1 <= tm_asa_poll_port_queue_id;
		end
		if (keep_d1) begin
			asa_tm_enq_desc <= desc_d1;
			asa_tm_enq_qid <= qid_d1;
			asa_tm_enq_conn_id <= conn_id_d1;
			asa_tm_enq_conn_group_id <= conn_group_id_d1;
			asa_tm_enq_port_queue_id <= port_queue_id_d1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/asa_pkt_pkg.sv ====
/* packet, buffer and read-count widths
   copy descriptor, pending copy and release payload types */
`default_nettype none

package asa_pkt_pkg;

	localparam int PORT_ID_NBITS = 3;
	localparam int BUF_PTR_NBITS = 10;
	localparam int PACKET_LENGTH_NBITS = 14;
	localparam int READ_COUNT_NBITS = 5;
	localparam int PACKET_ID_NBITS = 6;

	// travels with every copy, 30 bits
	typedef struct packed {
		logic [PORT_ID_NBITS-1:0] src_port;
		logic [PORT_ID_NBITS-1:0] dst_port;
		logic [BUF_PTR_NBITS-1:0] buf_ptr;
		logic [PACKET_LENGTH_NBITS-1:0] len;
	} copy_desc_t;

	// one replicated copy waiting for its poll ack
	typedef struct packed {
		logic ucast;
		logic last;
		logic drop;
		logic [PACKET_ID_NBITS-1:0] packet_id;
		logic [asa_tm_pkg::QID_NBITS-1:0] qid;
		copy_desc_t desc;
	} pending_copy_t;

	// buffer release toward the buffer manager
	typedef struct packed {
		logic [READ_COUNT_NBITS-1:0] read_count;
		logic [PORT_ID_NBITS-1:0] src_port;
		logic [BUF_PTR_NBITS-1:0] buf_ptr;
		logic [PACKET_LENGTH_NBITS-1:0] len;
	} release_t;

endpackage

`default_nettype wire

// ==== hdl/asa_read_count_tracker.sv ====
/* per-packet read-count RAM with post-reset clear sweep,
   write forwarding and final count output */
`timescale 1ns/1ns
`default_nettype none

module asa_read_count_tracker #(
	parameter int packet_id_nbits = 6
) (
	input wire clk,
	input wire arst_n,
	input wire ack_valid,
	input wire asa_pkt_pkg::pending_copy_t ack_copy,
	input wire tm_asa_poll_drop,
	output logic final_valid,
	output asa_pkt_pkg::release_t final_release
);

	localparam int rc_nbits = asa_pkt_pkg::READ_COUNT_NBITS;

	logic [rc_nbits-1:0] rc_ram [2**packet_id_nbits];

	logic clr_active;
	logic [packet_id_nbits-1:0] clr_addr;

	logic [packet_id_nbits-1:0] rd_addr;
	logic [rc_nbits-1:0] rd_data;
	logic ram_wr;
	logic [packet_id_nbits-1:0] wr_addr;
	logic [rc_nbits-1:0] wr_data;

	logic fwd_hit;
	logic [rc_nbits-1:0] fwd_data;

	logic s1_valid;
	logic s1_final;
	logic s1_drop;
	logic [packet_id_nbits-1:0] s1_id;
	logic [asa_pkt_pkg::PORT_ID_NBITS-1:0] s1_src_port;
	logic [asa_pkt_pkg::BUF_PTR_NBITS-1:0] s1_buf_ptr;
	logic [asa_pkt_pkg::PACKET_LENGTH_NBITS-1:0] s1_len;

	logic [rc_nbits-1:0] cur_count;
	logic [rc_nbits-1:0] new_count;

	assign rd_addr = ack_copy.packet_id[packet_id_nbits-1:0];

	// a write on the same edge as the read is missed by the RAM
	assign cur_count = fwd_hit ? fwd_data : rd_data;
	assign new_count = cur_count + rc_nbits'(!s1_drop);

	// final copy leaves the entry at zero for the next packet
	assign ram_wr = clr_active || s1_valid;
	assign wr_addr = clr_active ? clr_addr : s1_id;
	assign wr_data = (clr_active || s1_final) ? '0 : new_count;

	always_ff @(posedge clk) begin
		if (ram_wr) begin
			rc_ram[wr_addr] <= wr_data;
		end
		rd_data <= rc_ram[rd_addr];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			clr_active <= 1'b1;
			clr_addr <= '0;
			s1_valid <= 1'b0;
			fwd_hit <= 1'b0;
			final_valid <= 1'b0;
		end else begin
			if (clr_active) begin
				clr_addr <= clr_addr + 1'b1;
				if (&clr_addr) begin
					clr_active <= 1'b0;
				end
			end
			s1_valid <= ack_valid;
			fwd_hit <= ram_wr && (wr_addr == rd_addr);
			final_valid <= s1_valid && s1_final;
		end
	end

	always_ff @(posedge clk) begin
		fwd_data <= wr_data;
		s1_final <= ack_copy.ucast || ack_copy.last;
		// dropped by the replicator or by the traffic manager
		s1_drop <= ack_copy.drop || tm_asa_poll_drop;
		s1_id <= rd_addr;
		s1_src_port <= ack_copy.desc.src_port;
		s1_buf_ptr <= ack_copy.desc.buf_ptr;
		s1_len <= ack_copy.desc.len;
		if (s1_valid && s1_final) begin
			final_release.read_count <= new_count;
			final_release.src_port <= s1_src_port;
			final_release.buf_ptr <= s1_buf_ptr;
			final_release.len <= s1_len;
		end
	end

	a_no_ack_in_sweep: assert property (@(posedge clk) disable iff (!arst_n)
		ack_valid |-> !clr_active);

endmodule

`default_nettype wire

// ==== hdl/asa_release_merge.sv ====
/* release FIFO for tracker results, merged with discard requests
   toward the buffer manager */
`timescale 1ns/1ns
`default_nettype none

module asa_release_merge (
	input wire clk,
	input wire arst_n,
	input wire final_valid,
	input wire asa_pkt_pkg::release_t final_release,
	input wire discard_req,
	input wire [asa_pkt_pkg::PACKET_LENGTH_NBITS-1:0] discard_packet_length,
	input wire [asa_pkt_pkg::PORT_ID_NBITS-1:0] discard_src_port,
	input wire [asa_pkt_pkg::BUF_PTR_NBITS-1:0] discard_buf_ptr,
	output logic asa_bm_read_count_valid,
	output logic [asa_pkt_pkg::READ_COUNT_NBITS-1:0] asa_bm_read_count,
	output logic [asa_pkt_pkg::PACKET_LENGTH_NBITS-1:0] asa_bm_packet_length,
	output logic [asa_pkt_pkg::PORT_ID_NBITS-1:0] asa_bm_rc_port_id,
	output logic [asa_pkt_pkg::BUF_PTR_NBITS-1:0] asa_bm_buf_ptr
);

	localparam int rel_depth = 16;

	asa_pkt_pkg::release_t rel_head;
	logic rel_empty;
	logic rel_full;
	logic rel_rd;

	// discards take the output slot, tracker results wait
	assign rel_rd = !discard_req && !rel_empty;

	asa_sync_fifo #(
		.payload_t(asa_pkt_pkg::release_t),
		.depth(rel_depth)
	) u_release_fifo (
		.clk(clk),
		.arst_n(arst_n),
		.wr(final_valid),
		.din(final_release),
		.rd(rel_rd),
		.dout(rel_head),
		.empty(rel_empty),
		.full(rel_full),
		.count()
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			asa_bm_read_count_valid <= 1'b0;
		end else begin
			asa_bm_read_count_valid <= discard_req || !rel_empty;
		end
	end

	always_ff @(posedge clk) begin
		if (discard_req) begin
			asa_bm_read_count <= '0;
			asa_bm_packet_length <= discard_packet_length;
			asa_bm_rc_port_id <= discard_src_port;
			asa_bm_buf_ptr <= discard_buf_ptr;
		end else if (!rel_empty) begin
			asa_bm_read_count <= rel_head.read_count;
			asa_bm_packet_length <= rel_head.len;
			asa_bm_rc_port_id <= rel_head.src_port;
			asa_bm_buf_ptr <= rel_head.buf_ptr;
		end
	end

	// discard bursts must not starve the tracker into overflow
	a_rel_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		final_valid |-> !rel_full);

endmodule

`default_nettype wire

// ==== hdl/asa_sync_fifo.sv ====
/* first-word-fall-through synchronous FIFO, payload given as a type parameter */
`timescale 1ns/1ns
`default_nettype none

module asa_sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int depth = 16
) (
	input wire clk,
	input wire arst_n,
	input wire wr,
	input wire payload_t din,
	input wire rd,
	output payload_t dout,
	output logic empty,
	output logic full,
	output logic [$clog2(depth+1)-1:0] count
);

	localparam int ptr_nbits = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_nbits = $clog2(depth + 1);

	payload_t mem [depth];
	logic [ptr_nbits-1:0] wr_ptr;
	logic [ptr_nbits-1:0] rd_ptr;

	// head is visible without a read
	assign dout = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == cnt_nbits'(depth));

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr) begin
				wr_ptr <= (wr_ptr == ptr_nbits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd) begin
				rd_ptr <= (rd_ptr == ptr_nbits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr, rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) wr |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) rd |-> !empty);

endmodule

`default_nettype wire

// ==== hdl/asa_tm_interface.sv ====
/* replication to traffic manager adapter, top level */
`timescale 1ns/1ns
`default_nettype none

module asa_tm_interface #(
	parameter int packet_id_nbits = 6,
	parameter int pending_depth = 32
) (
	input wire clk,
	input wire arst_n,
	input wire discard_req,
	input wire [asa_pkt_pkg::PACKET_LENGTH_NBITS-1:0] discard_packet_length,
	input wire [asa_pkt_pkg::PORT_ID_NBITS-1:0] discard_src_port,
	input wire [asa_pkt_pkg::BUF_PTR_NBITS-1:0] discard_buf_ptr,
	input wire rep_enq_req,
	input wire rep_enq_drop,
	input wire rep_enq_ucast,
	input wire rep_enq_last,
	input wire [asa_pkt_pkg::PACKET_ID_NBITS-1:0] rep_enq_packet_id,
	input wire [asa_tm_pkg::QID_NBITS-1:0] rep_enq_qid,
	input wire asa_pkt_pkg::copy_desc_t rep_enq_desc,
	input wire tm_asa_poll_ack,
	input wire tm_asa_poll_drop,
	input wire [asa_tm_pkg::CONN_ID_NBITS-1:0] tm_asa_poll_conn_id,
	input wire [asa_tm_pkg::CONN_GROUP_NBITS-1:0] tm_asa_poll_conn_group_id,
	input wire [asa_tm_pkg::PORT_QUEUE_NBITS-1:0] tm_asa_poll_port_queue_id,
	input wire [asa_pkt_pkg::PORT_ID_NBITS-1:0] tm_asa_poll_port_id,
	output logic int_rep_bp,
	output logic asa_tm_poll_req,
	output logic [asa_tm_pkg::QID_NBITS-1:0] asa_tm_poll_qid,
	output logic [asa_pkt_pkg::PORT_ID_NBITS-1:0] asa_tm_poll_src_port,
	output logic asa_tm_enq_req,
	output logic [asa_tm_pkg::QID_NBITS-1:0] asa_tm_enq_qid,
	output logic [asa_tm_pkg::CONN_ID_NBITS-1:0] asa_tm_enq_conn_id,
	output logic [asa_tm_pkg::CONN_GROUP_NBITS-1:0] asa_tm_enq_conn_group_id,
	output logic [asa_tm_pkg::PORT_QUEUE_NBITS-1:0] asa_tm_enq_port_queue_id,
	output asa_pkt_pkg::copy_desc_t asa_tm_enq_desc,
	output logic asa_bm_read_count_valid,
	output logic [asa_pkt_pkg::READ_COUNT_NBITS-1:0] asa_bm_read_count,
	output logic [asa_pkt_pkg::PACKET_LENGTH_NBITS-1:0] asa_bm_packet_length,
	output logic [asa_pkt_pkg::PORT_ID_NBITS-1:0] asa_bm_rc_port_id,
	output logic [asa_pkt_pkg::BUF_PTR_NBITS-1:0] asa_bm_buf_ptr
);

	logic ack_valid;
	asa_pkt_pkg::pending_copy_t ack_copy;
	logic final_valid;
	asa_pkt_pkg::release_t final_release;

	asa_copy_intake #(
		.pending_depth(pending_depth)
	) u_intake (
		.clk(clk),
		.arst_n(arst_n),
		.rep_enq_req(rep_enq_req),
		.rep_enq_ucast(rep_enq_ucast),
		.rep_enq_last(rep_enq_last),
		.rep_enq_drop(rep_enq_drop),
		.rep_enq_packet_id(rep_enq_packet_id),
		.rep_enq_qid(rep_enq_qid),
		.rep_enq_desc(rep_enq_desc),
		.tm_asa_poll_ack(tm_asa_poll_ack),
		.int_rep_bp(int_rep_bp),
		.asa_tm_poll_req(asa_tm_poll_req),
		.asa_tm_poll_qid(asa_tm_poll_qid),
		.asa_tm_poll_src_port(asa_tm_poll_src_port),
		.ack_valid(ack_valid),
		.ack_copy(ack_copy)
	);

	asa_read_count_tracker #(
		.packet_id_nbits(packet_id_nbits)
	) u_tracker (
		.clk(clk),
		.arst_n(arst_n),
		.ack_valid(ack_valid),
		.ack_copy(ack_copy),
		.tm_asa_poll_drop(tm_asa_poll_drop),
		.final_valid(final_valid),
		.final_release(final_release)
	);

	asa_enq_builder u_enq_builder (
		.clk(clk),
		.arst_n(arst_n),
		.ack_valid(ack_valid),
		.ack_copy(ack_copy),
		.tm_asa_poll_drop(tm_asa_poll_drop),
		.tm_asa_poll_conn_id(tm_asa_poll_conn_id),
		.tm_asa_poll_conn_group_id(tm_asa_poll_conn_group_id),
		.tm_asa_poll_port_queue_id(tm_asa_poll_port_queue_id),
		.tm_asa_poll_port_id(tm_asa_poll_port_id),
		.asa_tm_enq_req(asa_tm_enq_req),
		.asa_tm_enq_qid(asa_tm_enq_qid),
		.asa_tm_enq_conn_id(asa_tm_enq_conn_id),
		.asa_tm_enq_conn_group_id(asa_tm_enq_conn_group_id),
		.asa_tm_enq_port_queue_id(asa_tm_enq_port_queue_id),
		.asa_tm_enq_desc(asa_tm_enq_desc)
	);

	asa_release_merge u_release_merge (
		.clk(clk),
		.arst_n(arst_n),
		.final_valid(final_valid),
		.final_release(final_release),
		.discard_req(discard_req),
		.discard_packet_length(discard_packet_length),
		.discard_src_port(discard_src_port),
		.discard_buf_ptr(discard_buf_ptr),
		.asa_bm_read_count_valid(asa_bm_read_count_valid),
		.asa_bm_read_count(asa_bm_read_count),
		.asa_bm_packet_length(asa_bm_packet_length),
		.asa_bm_rc_port_id(asa_bm_rc_port_id),
		.asa_bm_buf_ptr(asa_bm_buf_ptr)
	);

endmodule

`default_nettype wire

// ==== hdl/asa_tm_pkg.sv ====
/* traffic manager queue hierarchy widths and intake FIFO thresholds */
`default_nettype none

package asa_tm_pkg;

	// queue hierarchy, first to fourth level
	localparam int QID_NBITS = 6;
	localparam int CONN_ID_NBITS = 8;
	localparam int CONN_GROUP_NBITS = 6;
	localparam int PORT_QUEUE_NBITS = 4;

	localparam int INTAKE_DEPTH = 16;

	// back-pressure hysteresis on the intake count
	localparam int BP_ON_LEVEL = 11;
	localparam int BP_OFF_LEVEL = 5;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module tb_asa_tm_interface --Mdir obj_dir -o tb_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
grep -qx "TEST PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// ==== test/tb_asa_tm_interface.sv ====
/* testbench for the replication to traffic manager adapter
   table-driven copies, traffic manager model, enqueue and release checks */
`timescale 1ns/1ns
`default_nettype none

module tb_asa_tm_interface;

	localparam int n_rows = 13;
	localparam int bp_copies = 44;
	localparam int sweep_cycles = 2**6;
	localparam int cycle_limit = sweep_cycles + 40 * (n_rows + 1 + bp_copies) + 200;

	typedef struct packed {
		logic [asa_pkt_pkg::PACKET_ID_NBITS-1:0] pid;
		logic ucast;
		logic last;
		logic rep_drop;
		logic tm_drop;
		logic [asa_tm_pkg::QID_NBITS-1:0] qid;
		logic [asa_pkt_pkg::PORT_ID_NBITS-1:0] src;
		logic [asa_pkt_pkg::PORT_ID_NBITS-1:0] dst;
		logic [asa_pkt_pkg::BUF_PTR_NBITS-1:0] buf_ptr;
		logic [asa_pkt_pkg::PACKET_LENGTH_NBITS-1:0] len;
		logic [asa_pkt_pkg::READ_COUNT_NBITS-1:0] exp_rc;
	} row_t;

	typedef struct packed {
		logic [31:0] due;
		logic [asa_tm_pkg::QID_NBITS-1:0] qid;
		logic [asa_tm_pkg::CONN_ID_NBITS-1:0] conn_id;
		logic [asa_tm_pkg::CONN_GROUP_NBITS-1:0] grp_id;
		logic [asa_tm_pkg::PORT_QUEUE_NBITS-1:0] pq_id;
		asa_pkt_pkg::copy_desc_t desc;
	} enq_t;

	typedef struct packed {
		logic [31:0] due;
		logic [asa_pkt_pkg::READ_COUNT_NBITS-1:0] read_count;
		logic [asa_pkt_pkg::PORT_ID_NBITS-1:0] src_port;
		logic [asa_pkt_pkg::BUF_PTR_NBITS-1:0] buf_ptr;
		logic [asa_pkt_pkg::PACKET_LENGTH_NBITS-1:0] len;
	} rel_t;

	logic clk;
	logic arst_n;
	logic discard_req;
	logic [asa_pkt_pkg::PACKET_LENGTH_NBITS-1:0] discard_packet_length;
	logic [asa_pkt_pkg::PORT_ID_NBITS-1:0] discard_src_port;
	logic [asa_pkt_pkg::BUF_PTR_NBITS-1:0] discard_buf_ptr;
	logic rep_enq_req;
	logic rep_enq_drop;
	logic rep_enq_ucast;
	logic rep_enq_last;
	logic [asa_pkt_pkg::PACKET_ID_NBITS-1:0] rep_enq_packet_id;
	logic [asa_tm_pkg::QID_NBITS-1:0] rep_enq_qid;
	asa_pkt_pkg::copy_desc_t rep_enq_desc;
	logic tm_asa_poll_ack;
	logic tm_asa_poll_drop;
	logic [asa_tm_pkg::CONN_ID_NBITS-1:0] tm_asa_poll_conn_id;
	logic [asa_tm_pkg::CONN_GROUP_NBITS-1:0] tm_asa_poll_conn_group_id;
	logic [asa_tm_pkg::PORT_QUEUE_NBITS-1:0] tm_asa_poll_port_queue_id;
	logic [asa_pkt_pkg::PORT_ID_NBITS-1:0] tm_asa_poll_port_id;
	logic int_rep_bp;
	logic asa_tm_poll_req;
	logic [asa_tm_pkg::QID_NBITS-1:0] asa_tm_poll_qid;
	logic [asa_pkt_pkg::PORT_ID_NBITS-1:0] asa_tm_poll_src_port;
	logic asa_tm_enq_req;
	logic [asa_tm_pkg::QID_NBITS-1:0] asa_tm_enq_qid;
	logic [asa_tm_pkg::CONN_ID_NBITS-1:0] asa_tm_enq_conn_id;
	logic [asa_tm_pkg::CONN_GROUP_NBITS-1:0] asa_tm_enq_conn_group_id;
	logic [asa_tm_pkg::PORT_QUEUE_NBITS-1:0] asa_tm_enq_port_queue_id;
	asa_pkt_pkg::copy_desc_t asa_tm_enq_desc;
	logic asa_bm_read_count_valid;
	logic [asa_pkt_pkg::READ_COUNT_NBITS-1:0] asa_bm_read_count;
	logic [asa_pkt_pkg::PACKET_LENGTH_NBITS-1:0] asa_bm_packet_length;
	logic [asa_pkt_pkg::PORT_ID_NBITS-1:0] asa_bm_rc_port_id;
	logic [asa_pkt_pkg::BUF_PTR_NBITS-1:0] asa_bm_buf_ptr;

	asa_tm_interface #(
		.packet_id_nbits(6),
		.pending_depth(32)
	) dut (
		.*
	);

	// pid, ucast, last, rep drop, tm drop, qid, src, dst, buf_ptr, len, expected count
	row_t table_rows [n_rows] = '{
		'{6'd3, 1'b1, 1'b0, 1'b0, 1'b0, 6'd10, 3'd1, 3'd0, 10'h011, 14'd64, 5'd1},
		'{6'd5, 1'b0, 1'b0, 1'b0, 1'b0, 6'd11, 3'd2, 3'd0, 10'h022, 14'd1500, 5'd0},
		'{6'd5, 1'b0, 1'b0, 1'b0, 1'b1, 6'd12, 3'd2, 3'd1, 10'h022, 14'd1500, 5'd0},
		'{6'd5, 1'b0, 1'b1, 1'b0, 1'b0, 6'd13, 3'd2, 3'd2, 10'h022, 14'd1500, 5'd2},
		'{6'd7, 1'b0, 1'b0, 1'b1, 1'b0, 6'd20, 3'd4, 3'd0, 10'h033, 14'd256, 5'd0},
		'{6'd7, 1'b0, 1'b1, 1'b1, 1'b0, 6'd21, 3'd4, 3'd0, 10'h033, 14'd256, 5'd0},
		'{6'd9, 1'b1, 1'b0, 1'b0, 1'b1, 6'd30, 3'd5, 3'd3, 10'h044, 14'd9000, 5'd0},
		'{6'd5, 1'b0, 1'b0, 1'b0, 1'b0, 6'd40, 3'd6, 3'd0, 10'h055, 14'd128, 5'd0},
		'{6'd5, 1'b0, 1'b1, 1'b0, 1'b0, 6'd41, 3'd6, 3'd5, 10'h055, 14'd128, 5'd2},
		'{6'd12, 1'b0, 1'b0, 1'b0, 1'b0, 6'd50, 3'd7, 3'd0, 10'h066, 14'd777, 5'd0},
		'{6'd12, 1'b0, 1'b0, 1'b0, 1'b0, 6'd51, 3'd7, 3'd0, 10'h066, 14'd777, 5'd0},
		'{6'd12, 1'b0, 1'b0, 1'b1, 1'b0, 6'd52, 3'd7, 3'd0, 10'h066, 14'd777, 5'd0},
		'{6'd12, 1'b0, 1'b1, 1'b0, 1'b0, 6'd53, 3'd7, 3'd0, 10'h066, 14'd777, 5'd3}
	};
	// unicast copy whose release collides with a discard burst
	row_t probe_row = '{6'd33, 1'b1, 1'b0, 1'b0, 1'b0, 6'd60, 3'd3, 3'd0, 10'h3a5, 14'd2048,
		5'd1};

	row_t exp_polls [$];
	row_t ack_wait [$];
	enq_t exp_enqs [$];
	rel_t exp_rels [$];
	rel_t exp_discards [$];

	int cyc;
	int acks_sent;
	logic ack_enable;
	logic [31:0] rng;
	row_t polled;
	row_t acked;
	enq_t enq_new;
	enq_t enq_head;
	rel_t rel_new;
	rel_t rel_head;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic report_failure(input string reason);
		$display("%0t: %s", $time, reason);
		abort_run();
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			$display("ERR t=%0t %s got=0x%0h expected=0x%0h", $time, name, got, expected);
			abort_run();
		end
	endtask

	task automatic send_copy(input row_t r);
		@(negedge clk);
		discard_req = 1'b0;
		rep_enq_req = 1'b1;
		rep_enq_ucast = r.ucast;
		rep_enq_last = r.last;
		rep_enq_drop = r.rep_drop;
		rep_enq_packet_id = r.pid;
		rep_enq_qid = r.qid;
		rep_enq_desc = '{r.src, r.dst, r.buf_ptr, r.len};
		exp_polls.push_back(r);
	endtask

	task automatic send_discard(input int i);
		rel_t d;
		@(negedge clk);
		rep_enq_req = 1'b0;
		discard_req = 1'b1;
		discard_packet_length = 14'(100 + i);
		discard_src_port = 3'(i);
		discard_buf_ptr = 10'(10'h200 + i);
		d = '{32'(cyc + 1), 5'd0, discard_src_port, discard_buf_ptr, discard_packet_length};
		exp_discards.push_back(d);
	endtask

	task automatic idle_inputs();
		@(negedge clk);
		rep_enq_req = 1'b0;
		discard_req = 1'b0;
	endtask

	task automatic wait_drained();
		@(posedge clk);
		while (exp_polls.size() + ack_wait.size() + exp_enqs.size() + exp_rels.size()
			+ exp_discards.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(negedge clk);
	endtask

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= cycle_limit) begin
			report_failure("run did not finish within the cycle limit");
		end
	end

	// monitors first, then the traffic manager answers polls in order
	always @(negedge clk) begin
		if (arst_n) begin
			if (asa_tm_poll_req) begin
				if (exp_polls.size() == 0) begin
					report_failure("poll issued with no copy outstanding");
				end
				polled = exp_polls.pop_front();
				check_value("asa_tm_poll_qid", asa_tm_poll_qid, polled.qid);
				check_value("asa_tm_poll_src_port", asa_tm_poll_src_port, polled.src);
				ack_wait.push_back(polled);
			end
			if (exp_enqs.size() > 0 && exp_enqs[0].due == 32'(cyc)) begin
				enq_head = exp_enqs.pop_front();
				check_value("asa_tm_enq_req", asa_tm_enq_req, 1);
				check_value("asa_tm_enq_qid", asa_tm_enq_qid, enq_head.qid);
				check_value("asa_tm_enq_conn_id", asa_tm_enq_conn_id, enq_head.conn_id);
				check_value("asa_tm_enq_conn_group_id", asa_tm_enq_conn_group_id,
					enq_head.grp_id);
				check_value("asa_tm_enq_port_queue_id", asa_tm_enq_port_queue_id,
					enq_head.pq_id);
				check_value("asa_tm_enq_desc", asa_tm_enq_desc, enq_head.desc);
			end else if (asa_tm_enq_req) begin
				report_failure("enqueue issued with no acknowledged copy due");
			end
			if (exp_discards.size() > 0 && exp_discards[0].due == 32'(cyc)) begin
				rel_head = exp_discards.pop_front();
				check_value("asa_bm_read_count_valid", asa_bm_read_count_valid, 1);
			end else if (asa_bm_read_count_valid) begin
				if (exp_rels.size() == 0) begin
					report_failure("buffer release issued with no packet finished");
				end
				rel_head = exp_rels.pop_front();
			end
			if (asa_bm_read_count_valid) begin
				check_value("asa_bm_read_count", asa_bm_read_count, rel_head.read_count);
				check_value("asa_bm_packet_length", asa_bm_packet_length, rel_head.len);
				check_value("asa_bm_rc_port_id", asa_bm_rc_port_id, rel_head.src_port);
				check_value("asa_bm_buf_ptr", asa_bm_buf_ptr, rel_head.buf_ptr);
			end
			rng = lcg_next(rng);
			tm_asa_poll_ack = 1'b0;
			tm_asa_poll_drop = 1'b0;
			// random stall cycles between acks
			if (ack_enable && ack_wait.size() > 0 && rng[31:30] != 2'b00) begin
				acked = ack_wait.pop_front();
				tm_asa_poll_ack = 1'b1;
				tm_asa_poll_drop = acked.tm_drop;
				tm_asa_poll_conn_id = rng[23:16];
				tm_asa_poll_conn_group_id = rng[29:24];
				tm_asa_poll_port_queue_id = rng[15:12];
				tm_asa_poll_port_id = rng[11:9];
				if (!acked.rep_drop && !acked.tm_drop) begin
					enq_new = '{32'(cyc + 2), acked.qid, rng[23:16], rng[29:24], rng[15:12],
						'{acked.src, rng[11:9], acked.buf_ptr, acked.len}};
					exp_enqs.push_back(enq_new);
				end
				if (acked.ucast || acked.last) begin
					rel_new = '{32'd0, acked.exp_rc, acked.src, acked.buf_ptr, acked.len};
					exp_rels.push_back(rel_new);
				end
				acks_sent = acks_sent + 1;
			end
		end
	end

	initial begin
		int run_cnt;
		int target;
		row_t r;
		clk = 1'b0;
		arst_n = 1'b0;
		discard_req = 1'b0;
		discard_packet_length = '0;
		discard_src_port = '0;
		discard_buf_ptr = '0;
		rep_enq_req = 1'b0;
		rep_enq_drop = 1'b0;
		rep_enq_ucast = 1'b0;
		rep_enq_last = 1'b0;
		rep_enq_packet_id = '0;
		rep_enq_qid = '0;
		rep_enq_desc = '0;
		tm_asa_poll_ack = 1'b0;
		tm_asa_poll_drop = 1'b0;
		tm_asa_poll_conn_id = '0;
		tm_asa_poll_conn_group_id = '0;
		tm_asa_poll_port_queue_id = '0;
		tm_asa_poll_port_id = '0;
		cyc = 0;
		acks_sent = 0;
		ack_enable = 1'b0;
		rng = 32'd35225;
		run_cnt = 0;

		repeat (5) @(negedge clk);
		arst_n = 1'b1;
		// RAM clear sweep, nothing may leave the DUT
		repeat (sweep_cycles + 4) begin
			@(negedge clk);
			check_value("asa_tm_poll_req", asa_tm_poll_req, 0);
			check_value("asa_tm_enq_req", asa_tm_enq_req, 0);
			check_value("asa_bm_read_count_valid", asa_bm_read_count_valid, 0);
			check_value("int_rep_bp", int_rep_bp, 0);
		end

		@(posedge clk);
		ack_enable = 1'b1;
		for (int i = 0; i < n_rows; i++) begin
			send_copy(table_rows[i]);
		end
		idle_inputs();
		wait_drained();

		// discard burst across the probe's tracker release
		target = acks_sent + 1;
		send_copy(probe_row);
		idle_inputs();
		while (acks_sent < target) @(posedge clk);
		for (int i = 0; i < 4; i++) begin
			send_discard(i);
		end
		idle_inputs();
		wait_drained();

		// fill the pending FIFO, then 12 more copies back up in the intake
		@(posedge clk);
		ack_enable = 1'b0;
		for (int i = 0; i < bp_copies; i++) begin
			r = '0;
			r.pid = 6'(20 + i / 4);
			r.last = (i % 4 == 3);
			r.rep_drop = (i % 5 == 2);
			r.tm_drop = (i % 7 == 4);
			r.qid = 6'((i * 5) % 64);
			r.src = 3'((i / 4) % 8);
			r.buf_ptr = 10'(256 + i / 4);
			r.len = 14'(60 + 10 * (i / 4));
			if (i % 4 == 0) begin
				run_cnt = 0;
			end
			if (!r.rep_drop && !r.tm_drop) begin
				run_cnt = run_cnt + 1;
			end
			r.exp_rc = r.last ? 5'(run_cnt) : 5'd0;
			send_copy(r);
		end
		idle_inputs();
		repeat (3) @(negedge clk);
		check_value("int_rep_bp", int_rep_bp, 1);
		@(posedge clk);
		check_value("copies waiting for a poll", exp_polls.size(), 12);
		ack_enable = 1'b1;
		wait_drained();
		check_value("int_rep_bp", int_rep_bp, 0);

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire
